// ==== flist.f ====
+incdir+hw
hw/cam_pkg.sv
hw/video_pkg.sv
hw/frame_sync_fsm.sv
hw/cam_writer.sv
hw/frame_buffer.sv
hw/raster_timer.sv
hw/stereo_compositor.sv
hw/stereo_capture_top.sv
verification/stereo_assertions.sv
verification/tb_stereo_capture.sv

// ==== hw/cam_pkg.sv ====
`default_nettype none

`include "stereo_config.svh"

package cam_pkg;

    localparam int PIX_BITS      = 10;
    localparam int WORDS_PER_ROW = `WIN_X_SIZE / `PIX_PER_WORD;
    localparam int WIN_ROWS      = `WIN_Y_SIZE;
    localparam int COL_BITS      = $clog2(WORDS_PER_ROW);
    localparam int ROW_BITS      = $clog2(WIN_ROWS);
    localparam int IDX_BITS      = $clog2(`PIX_PER_WORD);

    typedef logic [PIX_BITS-1:0] pixel_t;

    // One camera beat, pixel 0 in the low bits
    typedef union packed {
        pixel_t [`PIX_PER_WORD-1:0]          pixels;
        logic   [`PIX_PER_WORD*PIX_BITS-1:0] raw;
    } mem_word_u;

    // Window row on top, column group below
    typedef logic [ROW_BITS+COL_BITS-1:0] mem_addr_t;

    typedef struct packed {
        logic      fv;
        logic      lv;
        mem_word_u data;
    } cam_stream_t;

endpackage

`default_nettype wire

// ==== hw/cam_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module cam_writer
    import cam_pkg::*;
(
    input  var logic      cam_clk,
    input  var logic      sys_reset,
    input  var logic      frame_start_i,
    input  var logic      line_active_i,
    input  var logic      line_end_i,
    input  var mem_word_u word_i,
    output var logic      we_o,
    output var mem_addr_t waddr_o,
    output var mem_word_u wdata_o
);

    // Two spare bits, counters saturate instead of wrapping back into the window
    localparam int COL_CNT_BITS = COL_BITS + 2;
    localparam int ROW_CNT_BITS = ROW_BITS + 2;

    logic [COL_CNT_BITS-1:0] col;
    logic [ROW_CNT_BITS-1:0] row;
    logic                    in_window;

    assign in_window = (col < COL_CNT_BITS'(WORDS_PER_ROW))
                    && (row < ROW_CNT_BITS'(WIN_ROWS));

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            col  <= '0;
            row  <= '0;
            we_o <= 1'b0;
        end else begin
            we_o <= line_active_i && in_window;

            // Column group restarts in every line gap
            if (!line_active_i) begin
                col <= '0;
            end else if (col != '1) begin
                col <= col + 1'b1;
            end

            if (frame_start_i) begin
                row <= '0;
            end else if (line_end_i && (row != '1)) begin
                row <= row + 1'b1;
            end
        end
    end

    always_ff @(posedge cam_clk) begin
        waddr_o <= {row[ROW_BITS-1:0], col[COL_BITS-1:0]};
        wdata_o <= word_i;
    end

endmodule

`default_nettype wire

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_buffer
    import cam_pkg::*;
(
    input  var logic      cam_clk,
    input  var logic      we_i,
    input  var mem_addr_t waddr_i,
    input  var mem_word_u wdata_i,
    input  var mem_addr_t raddr_i,
    output var mem_word_u rdata_o
);

    localparam int DEPTH = 2 ** $bits(mem_addr_t);

    logic [$bits(mem_word_u)-1:0] mem [DEPTH];

    always_ff @(posedge cam_clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i.raw;
        end
    end

    // Old data is returned when both ports hit the same word
    always_ff @(posedge cam_clk) begin
        rdata_o.raw <= mem[raddr_i];
    end

endmodule

`default_nettype wire

// ==== hw/frame_sync_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_sync_fsm
    import cam_pkg::*;
(
    input  var logic        cam_clk,
    input  var logic        sys_reset,
    input  var cam_stream_t stream_i,
    output var logic        frame_start_o,
    output var logic        line_active_o,
    output var logic        line_end_o,
    output var mem_word_u   word_o
);

    typedef enum logic [1:0] {
        WAIT_FRAME,
        LINE,
        GAP
    } state_t;

    state_t state;
    logic   fv_q;

    // Beats count only once a frame boundary has been seen
    assign line_active_o = (state != WAIT_FRAME) && stream_i.fv && stream_i.lv;
    assign word_o        = stream_i.data;

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            state         <= WAIT_FRAME;
            fv_q          <= 1'b0;
            frame_start_o <= 1'b0;
            line_end_o    <= 1'b0;
        end else begin
            fv_q          <= stream_i.fv;
            // First fv low after reset, or fv falling at the end of a frame
            frame_start_o <= !stream_i.fv && ((state == WAIT_FRAME) || fv_q);
            line_end_o    <= (state == LINE) && !line_active_o;

            case (state)
                WAIT_FRAME: begin
                    if (!stream_i.fv) begin
                        state <= GAP;
                    end
                end
                GAP: begin
                    if (line_active_o) begin
                        state <= LINE;
                    end
                end
                LINE: begin
                    if (!line_active_o) begin
                        state <= GAP;
                    end
                end
                default: begin
                    state <= WAIT_FRAME;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/raster_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stereo_config.svh"

module raster_timer
    import video_pkg::*;
(
    input  var logic        cam_clk,
    input  var logic        sys_reset,
    output var video_sync_t sync_o,
    output var h_pos_t      h_pos_o,
    output var v_pos_t      v_pos_o
);

    localparam int H_START = `H_SYNC + `H_BACK;
    localparam int H_END   = H_START + `H_ACTIVE;
    localparam int H_TOTAL = H_END + `H_FRONT;
    localparam int V_START = `V_SYNC + `V_BACK;
    localparam int V_END   = V_START + `V_ACTIVE;
    localparam int V_TOTAL = V_END + `V_FRONT;

    h_pos_t h_cnt;
    v_pos_t v_cnt;
    logic   h_act;
    logic   v_act;

    // ------------------------------
    // Line and frame counters
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_pos_t'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == v_pos_t'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ------------------------------
    // Region decode, sync sits at the start of each line and frame
    assign h_act = (h_cnt >= h_pos_t'(H_START)) && (h_cnt < h_pos_t'(H_END));
    assign v_act = (v_cnt >= v_pos_t'(V_START)) && (v_cnt < v_pos_t'(V_END));

    assign sync_o.hsync = !(h_cnt < h_pos_t'(`H_SYNC));
    assign sync_o.vsync = !(v_cnt < v_pos_t'(`V_SYNC));
    assign sync_o.de    = h_act && v_act;

    // Active coordinates, meaningful only while de is high
    assign h_pos_o = h_cnt - h_pos_t'(H_START);
    assign v_pos_o = v_cnt - v_pos_t'(V_START);

endmodule

`default_nettype wire

// ==== hw/stereo_capture_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module stereo_capture_top
    import cam_pkg::*, video_pkg::*;
(
    input  var logic        cam_clk,
    input  var logic        sys_reset,
    input  var cam_stream_t cam0_i,
    input  var cam_stream_t cam1_i,
    output var video_sync_t video_o,
    output var pixel_t      pixel_o
);

    cam_stream_t cam_stream [2];
    mem_addr_t   raddr      [2];
    mem_word_u   rdata      [2];
    video_sync_t timer_sync;
    h_pos_t      timer_h_pos;
    v_pos_t      timer_v_pos;

    assign cam_stream[0] = cam0_i;
    assign cam_stream[1] = cam1_i;

    // ------------------------------
    // Capture path, one per camera
    for (genvar c = 0; c < 2; c++) begin : g_cam
        logic      frame_start;
        logic      line_active;
        logic      line_end;
        logic      we;
        mem_word_u word;
        mem_word_u wdata;
        mem_addr_t waddr;

        frame_sync_fsm i_frame_sync_fsm (
            .cam_clk       (cam_clk),
            .sys_reset     (sys_reset),
            .stream_i      (cam_stream[c]),
            .frame_start_o (frame_start),
            .line_active_o (line_active),
            .line_end_o    (line_end),
            .word_o        (word)
        );

        cam_writer i_cam_writer (
            .cam_clk       (cam_clk),
            .sys_reset     (sys_reset),
            .frame_start_i (frame_start),
            .line_active_i (line_active),
            .line_end_i    (line_end),
            .word_i        (word),
            .we_o          (we),
            .waddr_o       (waddr),
            .wdata_o       (wdata)
        );

        frame_buffer i_frame_buffer (
            .cam_clk (cam_clk),
            .we_i    (we),
            .waddr_i (waddr),
            .wdata_i (wdata),
            .raddr_i (raddr[c]),
            .rdata_o (rdata[c])
        );
    end

    // ------------------------------
    // Display path
    raster_timer i_raster_timer (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .sync_o    (timer_sync),
        .h_pos_o   (timer_h_pos),
        .v_pos_o   (timer_v_pos)
    );

    stereo_compositor i_stereo_compositor (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .sync_i    (timer_sync),
        .h_pos_i   (timer_h_pos),
        .v_pos_i   (timer_v_pos),
        .rdata0_i  (rdata[0]),
        .rdata1_i  (rdata[1]),
        .raddr0_o  (raddr[0]),
        .raddr1_o  (raddr[1]),
        .sync_o    (video_o),
        .pixel_o   (pixel_o)
    );

endmodule

`default_nettype wire

// ==== hw/stereo_compositor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stereo_config.svh"

module stereo_compositor
    import cam_pkg::*, video_pkg::*;
(
    input  var logic        cam_clk,
    input  var logic        sys_reset,
    input  var video_sync_t sync_i,
    input  var h_pos_t      h_pos_i,
    input  var v_pos_t      v_pos_i,
    input  var mem_word_u   rdata0_i,
    input  var mem_word_u   rdata1_i,
    output var mem_addr_t   raddr0_o,
    output var mem_addr_t   raddr1_o,
    output var video_sync_t sync_o,
    output var pixel_t      pixel_o
);

    localparam video_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

    h_pos_t              x0;
    h_pos_t              x1;
    v_pos_t              y;
    logic                hit0;
    logic                hit1;
    logic                hit0_q;
    logic                hit1_q;
    logic [IDX_BITS-1:0] idx0_q;
    logic [IDX_BITS-1:0] idx1_q;
    video_sync_t         sync_q;

    // ------------------------------
    // Stage 0: window test and read address
    assign x0 = h_pos_i - h_pos_t'(`CAM0_X_OFF);
    assign x1 = h_pos_i - h_pos_t'(`CAM1_X_OFF);
    assign y  = v_pos_i - v_pos_t'(`CAM_Y_OFF);

    // Positions left of or above a window wrap to large values
    assign hit0 = sync_i.de && (x0 < h_pos_t'(`WIN_X_SIZE)) && (y < v_pos_t'(`WIN_Y_SIZE));
    assign hit1 = sync_i.de && (x1 < h_pos_t'(`WIN_X_SIZE)) && (y < v_pos_t'(`WIN_Y_SIZE));

    assign raddr0_o = {y[ROW_BITS-1:0], x0[IDX_BITS +: COL_BITS]};
    assign raddr1_o = {y[ROW_BITS-1:0], x1[IDX_BITS +: COL_BITS]};

    // ------------------------------
    // Stage 1 waits on the buffer read, stage 2 selects the pixel
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            hit0_q  <= 1'b0;
            hit1_q  <= 1'b0;
            sync_q  <= SYNC_IDLE;
            sync_o  <= SYNC_IDLE;
            pixel_o <= '0;
        end else begin
            hit0_q <= hit0;
            hit1_q <= hit1;
            sync_q <= sync_i;
            sync_o <= sync_q;

            if (hit0_q) begin
                pixel_o <= rdata0_i.pixels[idx0_q];
            end else if (hit1_q) begin
                pixel_o <= rdata1_i.pixels[idx1_q];
            end else begin
                pixel_o <= '0;
            end
        end
    end

    // Pixel index within the word
    always_ff @(posedge cam_clk) begin
        idx0_q <= x0[IDX_BITS-1:0];
        idx1_q <= x1[IDX_BITS-1:0];
    end

endmodule

`default_nettype wire

// ==== hw/stereo_config.svh ====
`ifndef STEREO_CONFIG_SVH
`define STEREO_CONFIG_SVH

// Stored camera window
`define WIN_X_SIZE      16
`define WIN_Y_SIZE      8
`define PIX_PER_WORD    4

// ------------------------------
// Horizontal timing in pixels, in order from line start
`define H_SYNC          8
`define H_BACK          4
`define H_ACTIVE        64
`define H_FRONT         4

// Vertical timing in lines
`define V_SYNC          2
`define V_BACK          1
`define V_ACTIVE        20
`define V_FRONT         1

// ------------------------------
// Window positions in active display coordinates
`define CAM0_X_OFF      8
`define CAM1_X_OFF      40
`define CAM_Y_OFF       6

`endif

// ==== hw/video_pkg.sv ====
`default_nettype none

package video_pkg;

    typedef logic [6:0] h_pos_t;
    typedef logic [4:0] v_pos_t;

    // hsync and vsync are active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } video_sync_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the stereo capture testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_stereo_capture -o sim_stereo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_stereo +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** PASSED ***"; then
    exit 0
fi
exit 1

// ==== verification/stereo_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module stereo_assertions
    import video_pkg::*;
(
    input  var logic        cam_clk,
    input  var logic        sys_reset,
    input  var video_sync_t video_i,
    input  var logic        we0_i,
    input  var logic        we1_i,
    input  var logic [1:0]  state0_i,
    input  var logic [1:0]  state1_i
);

    // First state of frame_sync_fsm
    localparam logic [1:0] WAIT_FRAME = 2'd0;

    int fail_cnt = 0;

    // Display enable only starts outside both sync pulses
    de_outside_sync: assert property (@(posedge cam_clk) disable iff (sys_reset)
        $rose(video_i.de) |-> (video_i.hsync && video_i.vsync))
    else begin
        fail_cnt++;
        $error("display enable rose while a sync pulse was active");
    end

    // ------------------------------
    // No buffer write before a frame boundary was seen
    cam0_write_after_sync: assert property (@(posedge cam_clk) disable iff (sys_reset)
        we0_i |-> (state0_i != WAIT_FRAME))
    else begin
        fail_cnt++;
        $error("camera 0 buffer written while its FSM waits for a frame");
    end

    cam1_write_after_sync: assert property (@(posedge cam_clk) disable iff (sys_reset)
        we1_i |-> (state1_i != WAIT_FRAME))
    else begin
        fail_cnt++;
        $error("camera 1 buffer written while its FSM waits for a frame");
    end

endmodule

bind stereo_capture_top stereo_assertions i_stereo_assertions (
    .cam_clk   (cam_clk),
    .sys_reset (sys_reset),
    .video_i   (video_o),
    .we0_i     (g_cam[0].we),
    .we1_i     (g_cam[1].we),
    .state0_i  (g_cam[0].i_frame_sync_fsm.state),
    .state1_i  (g_cam[1].i_frame_sync_fsm.state)
);

`default_nettype wire

// ==== verification/tb_stereo_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stereo_config.svh"

module tb_stereo_capture
    import cam_pkg::*, video_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int H_START     = `H_SYNC + `H_BACK;
    localparam int H_TOTAL     = H_START + `H_ACTIVE + `H_FRONT;
    localparam int V_START     = `V_SYNC + `V_BACK;
    localparam int V_TOTAL     = V_START + `V_ACTIVE + `V_FRONT;
    localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
    localparam int WIN_WORDS   = `WIN_X_SIZE / `PIX_PER_WORD;
    // Longest camera frame is 3 blank beats and 11 lines of 7 beats plus 3 gap beats
    localparam int CAM_CYC     = 3 + 11 * (7 + 3);
    localparam int TIMEOUT_CYC = 3 * FRAME_CYC + 2 * CAM_CYC + 20;
    localparam int NUM_TESTS   = 6;

    logic        cam_clk;
    logic        sys_reset;
    cam_stream_t cam0_i;
    cam_stream_t cam1_i;
    video_sync_t video_o;
    pixel_t      pixel_o;

    int          seed = 85;
    logic [39:0] exp_win [2][32];
    logic [39:0] old_win [2][32];
    logic [39:0] clip_win [2][32];
    logic        clip_hit [2][32];
    int          checks [NUM_TESTS];
    int          errors [NUM_TESTS];
    string       test_name [NUM_TESTS];
    int          hc;
    int          vc;
    int          de_cnt;
    int          hs_cnt;
    int          act_lines;
    int          vs_lines;
    int          total_checks;
    int          total_errors;

    stereo_capture_top i_stereo_capture_top (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .cam0_i    (cam0_i),
        .cam1_i    (cam1_i),
        .video_o   (video_o),
        .pixel_o   (pixel_o)
    );

    initial begin
        cam_clk = 1'b0;
        forever #(CLK_PERIOD / 2) cam_clk = ~cam_clk;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the display check ended",
                 TIMEOUT_CYC);
        $display("*** FAILED ***");
        $finish;
    end

    // ------------------------------
    // Stimulus helpers
    function automatic int rand_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [39:0] rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[39:0];
    endfunction

    function automatic pixel_t word_pixel(input logic [39:0] word, input int idx);
        return word[idx * $bits(pixel_t) +: $bits(pixel_t)];
    endfunction

    function automatic logic in_window(input int x, input int y, input int x_off);
        return (x >= x_off) && (x < x_off + `WIN_X_SIZE)
            && (y >= `CAM_Y_OFF) && (y < `CAM_Y_OFF + `WIN_Y_SIZE);
    endfunction

    task automatic drive_beat(input int cam, input logic fv, input logic lv,
                              input logic [39:0] data);
        @(posedge cam_clk);
        if (cam == 0) begin
            cam0_i <= {fv, lv, data};
        end else begin
            cam1_i <= {fv, lv, data};
        end
    endtask

    // Two frames per camera with the window model and the clipped beats
    task automatic drive_camera(input int cam);
        int          lines;
        int          len;
        int          alias_addr;
        logic [39:0] data;
        for (int f = 0; f < 2; f++) begin
            for (int a = 0; a < 32; a++) begin
                clip_hit[cam][a] = 1'b0;
            end
            repeat (3) drive_beat(cam, 1'b0, 1'b0, rand_word());
            lines = 8 + rand_range(4);
            for (int ln = 0; ln < lines; ln++) begin
                len = 5 + rand_range(3);
                for (int col = 0; col < len; col++) begin
                    data = rand_word();
                    drive_beat(cam, 1'b1, 1'b1, data);
                    if (col < WIN_WORDS && ln < `WIN_Y_SIZE) begin
                        exp_win[cam][ln * WIN_WORDS + col] = data;
                    end else begin
                        // Word a clipped beat would land on through the low address bits
                        alias_addr = (ln % `WIN_Y_SIZE) * WIN_WORDS + col % WIN_WORDS;
                        clip_win[cam][alias_addr] = data;
                        clip_hit[cam][alias_addr] = 1'b1;
                    end
                end
                repeat (2 + rand_range(2)) drive_beat(cam, 1'b1, 1'b0, rand_word());
            end
            if (f == 0) begin
                for (int a = 0; a < 32; a++) begin
                    old_win[cam][a] = exp_win[cam][a];
                end
            end
        end
        drive_beat(cam, 1'b0, 1'b0, '0);
    endtask

    // ------------------------------
    // Checking
    task automatic check_value(input int test, input string name,
                               input logic [39:0] got, input logic [39:0] exp);
        checks[test]++;
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h at h=%0d v=%0d", name, got, exp, hc, vc);
            errors[test]++;
        end
    endtask

    task automatic check_idle();
        check_value(5, "de_o", 40'(video_o.de), 40'(0));
        check_value(5, "hsync_o", 40'(video_o.hsync), 40'(1));
        check_value(5, "vsync_o", 40'(video_o.vsync), 40'(1));
        check_value(5, "pixel_o", 40'(pixel_o), 40'(0));
    endtask

    task automatic window_check(input int cam, input int wx, input int wy);
        int     addr;
        int     idx;
        pixel_t new_pix;
        pixel_t old_pix;
        pixel_t clip_pix;
        addr     = wy * WIN_WORDS + wx / `PIX_PER_WORD;
        idx      = wx % `PIX_PER_WORD;
        new_pix  = word_pixel(exp_win[cam][addr], idx);
        old_pix  = word_pixel(old_win[cam][addr], idx);
        clip_pix = word_pixel(clip_win[cam][addr], idx);
        check_value(cam, "pixel_o", 40'(pixel_o), 40'(new_pix));
        // Second frame must have replaced the first
        if (old_pix != new_pix) begin
            checks[2]++;
            assert (pixel_o !== old_pix) else begin
                $display("FAIL pixel_o %h still holds the first frame at h=%0d v=%0d",
                         pixel_o, hc, vc);
                errors[2]++;
            end
        end
        // Beats outside the window must not reach the word they alias to
        if (clip_hit[cam][addr] && (clip_pix != new_pix)) begin
            checks[2]++;
            assert (pixel_o !== clip_pix) else begin
                $display("FAIL pixel_o %h is a clipped beat, expected %h at h=%0d v=%0d",
                         pixel_o, new_pix, hc, vc);
                errors[2]++;
            end
        end
    endtask

    task automatic check_pixel();
        int   x;
        int   y;
        logic exp_de;
        x      = hc - H_START;
        y      = vc - V_START;
        exp_de = (x >= 0) && (x < `H_ACTIVE) && (y >= 0) && (y < `V_ACTIVE);
        if (!video_o.hsync) begin
            hs_cnt++;
        end
        if (video_o.de) begin
            de_cnt++;
        end
        if (hc == 0 && !video_o.vsync) begin
            vs_lines++;
        end
        check_value(4, "de_o", 40'(video_o.de), 40'(exp_de));
        if (exp_de && in_window(x, y, `CAM0_X_OFF)) begin
            window_check(0, x - `CAM0_X_OFF, y - `CAM_Y_OFF);
        end else if (exp_de && in_window(x, y, `CAM1_X_OFF)) begin
            window_check(1, x - `CAM1_X_OFF, y - `CAM_Y_OFF);
        end else begin
            check_value(3, "pixel_o", 40'(pixel_o), 40'(0));
        end
    endtask

    task automatic end_line();
        int exp_de_cnt;
        exp_de_cnt = (vc >= V_START && vc < V_START + `V_ACTIVE) ? `H_ACTIVE : 0;
        check_value(4, "de_o high count", 40'(de_cnt), 40'(exp_de_cnt));
        check_value(4, "hsync_o low count", 40'(hs_cnt), 40'(`H_SYNC));
        if (de_cnt > 0) begin
            act_lines++;
        end
        de_cnt = 0;
        hs_cnt = 0;
    endtask

    // Position counted from the sync edges of the output itself
    task automatic check_frame();
        logic hs_q;
        logic vs_q;
        @(negedge cam_clk);
        vs_q = video_o.vsync;
        @(negedge cam_clk);
        while (!(vs_q && !video_o.vsync)) begin
            vs_q = video_o.vsync;
            @(negedge cam_clk);
        end
        hc        = 0;
        vc        = 0;
        de_cnt    = 0;
        hs_cnt    = 0;
        act_lines = 0;
        vs_lines  = 0;
        hs_q      = 1'b0;
        for (int n = 0; n < FRAME_CYC; n++) begin
            if (n > 0) begin
                @(negedge cam_clk);
                if (hs_q && !video_o.hsync) begin
                    end_line();
                    hc = 0;
                    vc = (vs_q && !video_o.vsync) ? 0 : vc + 1;
                end else begin
                    hc++;
                end
            end
            hs_q = video_o.hsync;
            vs_q = video_o.vsync;
            check_pixel();
        end
        end_line();
        check_value(4, "active line count", 40'(act_lines), 40'(`V_ACTIVE));
        check_value(4, "vsync line count", 40'(vs_lines), 40'(`V_SYNC));
    endtask

    task automatic report_test(input int t);
        if (checks[t] == 0) begin
            $display("Test %s ran no checks", test_name[t]);
            errors[t]++;
        end
        $display("test %0d %s: %0d checks, %0d errors",
                 t + 1, test_name[t], checks[t], errors[t]);
    endtask

    // ------------------------------
    // Main sequence
    initial begin
        sys_reset = 1'b1;
        cam0_i    = '0;
        cam1_i    = '0;
        hc        = 0;
        vc        = 0;
        test_name = '{"cam0 window", "cam1 window", "clipping and replace",
                      "background", "raster timing", "reset state"};
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end

        repeat (5) begin
            @(negedge cam_clk);
            check_idle();
        end
        @(posedge cam_clk);
        sys_reset <= 1'b0;
        repeat (2) begin
            @(negedge cam_clk);
            check_idle();
        end
        report_test(5);

        fork
            drive_camera(0);
            drive_camera(1);
        join

        check_frame();
        for (int t = 0; t < 5; t++) begin
            report_test(t);
        end

        total_checks = 0;
        total_errors = i_stereo_capture_top.i_stereo_assertions.fail_cnt;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Total: %0d checks, %0d errors, %0d assertion failures", total_checks,
                 total_errors, i_stereo_capture_top.i_stereo_assertions.fail_cnt);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
